// ==== common/rider_status_pkg.sv ====
package rider_status_pkg;

  // Firmware revision, shown in register 0
  localparam logic [7:0] MAJOR_REV = 8'd2;
  localparam logic [7:0] MINOR_REV = 8'd4;
  localparam logic [7:0] PATCH_REV = 8'd1;

  localparam int WORD_W       = 32;
  localparam int ADDR_W       = 5;
  localparam int COUNT_W      = 32;  // Soft-error counters and thresholds
  localparam int TRIG_NUM_W   = 24;
  localparam int TS_W         = 44;  // Trigger timestamp
  localparam int NUM_SOFT_ERR = 3;

  localparam int NUM_STATUS_REGS  = 19;
  localparam int MIN_TRIG_SPACING = 8;  // Cycles between triggers

  typedef logic [ADDR_W-1:0] status_addr_t;
  typedef logic [WORD_W-1:0] status_word_t;
  typedef status_word_t [NUM_STATUS_REGS-1:0] status_array_t;

  localparam status_word_t BAD_ADDR_WORD   = 32'hDEAD_ADD0;  // Read past the last word
  localparam status_word_t FW_VERSION_WORD = {1'b1, 7'd0, MAJOR_REV, MINOR_REV, PATCH_REV};

  // Status word index
  typedef enum logic [ADDR_W-1:0] {
    STAT_FW_VERSION        = 5'd0,
    STAT_ERROR             = 5'd1,
    STAT_EXT_CLK           = 5'd2,
    STAT_CLK_SYNTH         = 5'd3,
    STAT_DAQ_LINK          = 5'd4,
    STAT_TTC_TTS           = 5'd5,
    STAT_FSM0              = 5'd6,
    STAT_FSM1              = 5'd7,
    STAT_ACQ               = 5'd8,
    STAT_TRIG_INFO         = 5'd9,
    STAT_TRIG_NUM          = 5'd10,
    STAT_TS_LSB            = 5'd11,
    STAT_TS_MSB            = 5'd12,
    STAT_CORRUPT_THRES     = 5'd13,
    STAT_CORRUPT_COUNT     = 5'd14,
    STAT_UNKNOWN_TTC_THRES = 5'd15,
    STAT_UNKNOWN_TTC_COUNT = 5'd16,
    STAT_DDR3_OVF_THRES    = 5'd17,
    STAT_DDR3_OVF_COUNT    = 5'd18
  } status_reg_e;

  typedef struct packed {
    logic [COUNT_W-1:0] thres_data_corrupt;
    logic [COUNT_W-1:0] thres_unknown_ttc;
    logic [COUNT_W-1:0] thres_ddr3_overflow;
  } soft_err_cfg_t;

  typedef struct packed {
    logic [COUNT_W-1:0] cs_mismatch_count;
    logic [COUNT_W-1:0] unknown_cmd_count;
    logic [COUNT_W-1:0] ddr3_overflow_count;
    logic               error_data_corrupt;     // Sticky
    logic               error_unknown_ttc;      // Sticky
    logic               ddr3_overflow_warning;  // Sticky
  } soft_err_stat_t;

  typedef struct packed {
    logic       error_trig_num_from_tt;
    logic       error_trig_type_from_tt;
    logic       error_trig_num_from_cm;
    logic       error_trig_type_from_cm;
    logic       error_pll_unlock;
    logic [4:0] chan_error_rc;
  } hard_err_t;

  // Fields copied into the status words as they come
  typedef struct packed {
    logic        daq_clk_sel;
    logic        daq_clk_en;
    logic        adcclk_clkin0_stat;
    logic        adcclk_clkin1_stat;
    logic        adcclk_stat_ld;
    logic        adcclk_stat;
    logic        daq_almost_full;
    logic        daq_ready;
    logic [3:0]  tts_state;
    logic [5:0]  ttc_chan_b_info;
    logic        ttc_ready;
    logic [30:0] cm_state;
    logic [3:0]  ttr_state;
    logic [3:0]  cac_state;
    logic [6:0]  tp_state;
    logic [4:0]  acq_readout_pause;
    logic [1:0]  fill_type;
    logic [4:0]  chan_en;
    logic        endianness_sel;
    logic        trig_fifo_full;
    logic        acq_fifo_full;
    logic [3:0]  trig_delay;
    logic [7:0]  trig_settings;
  } board_stat_t;

  typedef struct packed {
    logic [TRIG_NUM_W-1:0] trig_num;
    logic [TS_W-1:0]       trig_timestamp;
    logic                  error_trig_rate;
  } trig_info_t;

endpackage

// ==== hw/soft_error_counter.sv ====
module soft_error_counter import rider_status_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           clear_errors,   // Zeroes counts and flags
  input  logic           cs_mismatch,
  input  logic           unknown_ttc_cmd,
  input  logic           ddr3_overflow,
  input  soft_err_cfg_t  soft_err_cfg,
  output soft_err_stat_t soft_err_stat
);

  // Channel 0 data corruption, 1 unknown TTC, 2 DDR3 overflow
  logic [NUM_SOFT_ERR-1:0]              err_pulse;
  logic [NUM_SOFT_ERR-1:0][COUNT_W-1:0] err_thres;
  logic [NUM_SOFT_ERR-1:0][COUNT_W-1:0] err_count;
  logic [NUM_SOFT_ERR-1:0][COUNT_W-1:0] count_nxt;
  logic [NUM_SOFT_ERR-1:0]              err_flag;

  assign err_pulse = {ddr3_overflow, unknown_ttc_cmd, cs_mismatch};
  assign err_thres = {soft_err_cfg.thres_ddr3_overflow,
                      soft_err_cfg.thres_unknown_ttc,
                      soft_err_cfg.thres_data_corrupt};

  always_comb begin
    for (int i = 0; i < NUM_SOFT_ERR; i++) begin
      // Saturate at all ones
      count_nxt[i] = (err_count[i] == '1) ? err_count[i] : err_count[i] + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || clear_errors) begin  // Clear beats a pulse in the same cycle
      err_count <= '0;
      err_flag  <= '0;
    end else begin
      for (int i = 0; i < NUM_SOFT_ERR; i++) begin
        if (err_pulse[i]) begin
          err_count[i] <= count_nxt[i];
          if (count_nxt[i] > err_thres[i]) begin
            err_flag[i] <= 1'b1;  // Held until clear_errors
          end
        end
      end
    end
  end

  assign soft_err_stat.cs_mismatch_count     = err_count[0];
  assign soft_err_stat.unknown_cmd_count     = err_count[1];
  assign soft_err_stat.ddr3_overflow_count   = err_count[2];
  assign soft_err_stat.error_data_corrupt    = err_flag[0];
  assign soft_err_stat.error_unknown_ttc     = err_flag[1];
  assign soft_err_stat.ddr3_overflow_warning = err_flag[2];

  // A full counter stays full unless cleared
  for (genvar i = 0; i < NUM_SOFT_ERR; i++) begin : g_no_wrap
    assert property (@(posedge clk) disable iff (reset)
      (!$past(reset) && !$past(clear_errors) && ($past(err_count[i]) == '1))
        |-> (err_count[i] == '1))
      else $error("soft error count %0d wrapped", i);
  end

endmodule

// ==== hw/trigger_capture.sv ====
module trigger_capture import rider_status_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       clear_errors,
  input  logic       trig,          // One-cycle pulse
  output trig_info_t trig_info
);

  logic [TS_W-1:0] ts_cnt;      // Free-running timestamp
  logic            have_prev;   // At least one trigger seen
  logic [TS_W-1:0] spacing;
  logic            too_close;

  // Cycles since the previous trigger's edge
  assign spacing   = ts_cnt - trig_info.trig_timestamp;
  assign too_close = have_prev && (spacing < TS_W'(MIN_TRIG_SPACING));

  always_ff @(posedge clk) begin
    if (reset) begin
      ts_cnt                    <= '0;
      have_prev                 <= 1'b0;
      trig_info.trig_num        <= '0;
      trig_info.trig_timestamp  <= '0;
      trig_info.error_trig_rate <= 1'b0;
    end else begin
      ts_cnt <= ts_cnt + 1'b1;
      if (trig) begin
        trig_info.trig_num       <= trig_info.trig_num + 1'b1;  // First one is 1
        trig_info.trig_timestamp <= ts_cnt;                     // Count before this edge
        have_prev                <= 1'b1;
      end
      if (clear_errors) begin
        trig_info.error_trig_rate <= 1'b0;
      end else if (trig && too_close) begin
        trig_info.error_trig_rate <= 1'b1;
      end
    end
  end

  // Trigger number moves only on a trigger
  assert property (@(posedge clk) disable iff (reset)
    (!$past(reset) && !$past(trig)) |-> $stable(trig_info.trig_num))
    else $error("trig_num changed without a trigger");

endmodule

// ==== status/status_reg_block.sv ====
module status_reg_block import rider_status_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  soft_err_cfg_t  soft_err_cfg,   // Thresholds
  input  soft_err_stat_t soft_err_stat,  // Counts and sticky flags
  input  hard_err_t      hard_err,
  input  board_stat_t    board_stat,
  input  trig_info_t     trig_info,
  output status_array_t  status_words
);

  status_array_t words_nxt;

  always_comb begin
    words_nxt = '0;
    words_nxt[STAT_FW_VERSION] = FW_VERSION_WORD;

    // Hard errors plus the flags from the front stages
    words_nxt[STAT_ERROR] = {18'd0, soft_err_stat.ddr3_overflow_warning,
                             hard_err.chan_error_rc,
                             hard_err.error_trig_type_from_cm,
                             hard_err.error_trig_type_from_tt,
                             hard_err.error_trig_num_from_cm,
                             hard_err.error_trig_num_from_tt,
                             soft_err_stat.error_data_corrupt,
                             trig_info.error_trig_rate,
                             soft_err_stat.error_unknown_ttc,
                             hard_err.error_pll_unlock};

    words_nxt[STAT_EXT_CLK] = {30'd0, board_stat.daq_clk_sel, board_stat.daq_clk_en};
    words_nxt[STAT_CLK_SYNTH] = {28'd0, board_stat.adcclk_clkin1_stat,
                                 board_stat.adcclk_clkin0_stat,
                                 board_stat.adcclk_stat_ld,
                                 board_stat.adcclk_stat};
    words_nxt[STAT_DAQ_LINK] = {30'd0, board_stat.daq_almost_full, board_stat.daq_ready};
    words_nxt[STAT_TTC_TTS] = {21'd0, board_stat.tts_state, board_stat.ttc_chan_b_info,
                               board_stat.ttc_ready};

    // FSM states
    words_nxt[STAT_FSM0] = {1'b0, board_stat.cm_state};
    words_nxt[STAT_FSM1] = {17'd0, board_stat.tp_state, board_stat.cac_state,
                            board_stat.ttr_state};

    words_nxt[STAT_ACQ] = {19'd0, board_stat.endianness_sel, board_stat.acq_readout_pause,
                           board_stat.fill_type, board_stat.chan_en};
    words_nxt[STAT_TRIG_INFO] = {18'd0, board_stat.trig_settings, board_stat.acq_fifo_full,
                                 board_stat.trig_fifo_full, board_stat.trig_delay};

    // Trigger number and 44-bit timestamp split over two words
    words_nxt[STAT_TRIG_NUM] = {8'd0, trig_info.trig_num};
    words_nxt[STAT_TS_LSB]   = trig_info.trig_timestamp[31:0];
    words_nxt[STAT_TS_MSB]   = {20'd0, trig_info.trig_timestamp[TS_W-1:32]};

    // Threshold and count pairs
    words_nxt[STAT_CORRUPT_THRES]     = soft_err_cfg.thres_data_corrupt;
    words_nxt[STAT_CORRUPT_COUNT]     = soft_err_stat.cs_mismatch_count;
    words_nxt[STAT_UNKNOWN_TTC_THRES] = soft_err_cfg.thres_unknown_ttc;
    words_nxt[STAT_UNKNOWN_TTC_COUNT] = soft_err_stat.unknown_cmd_count;
    words_nxt[STAT_DDR3_OVF_THRES]    = soft_err_cfg.thres_ddr3_overflow;
    words_nxt[STAT_DDR3_OVF_COUNT]    = soft_err_stat.ddr3_overflow_count;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      status_words                  <= '0;
      status_words[STAT_FW_VERSION] <= FW_VERSION_WORD;  // Version readable during reset
    end else begin
      status_words <= words_nxt;
    end
  end

  // Timestamp MSB word only carries TS_W-32 bits
  assert property (@(posedge clk) status_words[STAT_TS_MSB][WORD_W-1:TS_W-32] == '0)
    else $error("timestamp MSB word has high bits set");

endmodule

// ==== status/status_read_port.sv ====
module status_read_port import rider_status_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          rd_strobe,     // One-cycle read request
  input  status_addr_t  rd_addr,
  input  status_array_t status_words,
  output status_word_t  rd_data,       // Valid with rd_ack
  output logic          rd_ack
);

  logic         addr_ok;
  status_word_t word_sel;

  assign addr_ok  = (rd_addr < ADDR_W'(NUM_STATUS_REGS));
  assign word_sel = addr_ok ? status_words[rd_addr] : BAD_ADDR_WORD;

  // Ack the cycle after every strobe, no stalls
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= rd_strobe;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_strobe) begin
      rd_data <= word_sel;  // Held until the next read
    end
  end

  // Strobe answered exactly one cycle later
  assert property (@(posedge clk) disable iff (reset)
    rd_strobe |=> rd_ack)
    else $error("read strobe without ack");

endmodule

// ==== hw/rider_status_top.sv ====
module rider_status_top import rider_status_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          clear_errors,     // Pulse
  input  logic          cs_mismatch,      // Soft-error pulses
  input  logic          unknown_ttc_cmd,
  input  logic          ddr3_overflow,
  input  soft_err_cfg_t soft_err_cfg,
  input  hard_err_t     hard_err,
  input  board_stat_t   board_stat,
  input  logic          trig,
  input  logic          rd_strobe,
  input  status_addr_t  rd_addr,
  output status_word_t  rd_data,
  output logic          rd_ack
);

  soft_err_stat_t soft_err_stat;
  trig_info_t     trig_info;
  status_array_t  status_words;

  soft_error_counter soft_error_counter_inst (
    .clk             (clk),
    .reset           (reset),
    .clear_errors    (clear_errors),
    .cs_mismatch     (cs_mismatch),
    .unknown_ttc_cmd (unknown_ttc_cmd),
    .ddr3_overflow   (ddr3_overflow),
    .soft_err_cfg    (soft_err_cfg),
    .soft_err_stat   (soft_err_stat)
  );

  trigger_capture trigger_capture_inst (
    .clk          (clk),
    .reset        (reset),
    .clear_errors (clear_errors),
    .trig         (trig),
    .trig_info    (trig_info)
  );

  status_reg_block status_reg_block_inst (
    .clk           (clk),
    .reset         (reset),
    .soft_err_cfg  (soft_err_cfg),
    .soft_err_stat (soft_err_stat),
    .hard_err      (hard_err),
    .board_stat    (board_stat),
    .trig_info     (trig_info),
    .status_words  (status_words)
  );

  status_read_port status_read_port_inst (
    .clk          (clk),
    .reset        (reset),
    .rd_strobe    (rd_strobe),
    .rd_addr      (rd_addr),
    .status_words (status_words),
    .rd_data      (rd_data),
    .rd_ack       (rd_ack)
  );

endmodule

// ==== verification/rider_status_tb.sv ====
module rider_status_tb import rider_status_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // One row of the stimulus table
  typedef struct packed {
    bit          clear;      // clear_errors pulse before the pulses
    int          n_cs;
    int          n_ttc;
    int          n_ddr;
    int          n_trig;
    int          trig_gap;   // Cycles between triggers
    logic [31:0] th_cs;
    logic [31:0] th_ttc;
    logic [31:0] th_ddr;
    logic [31:0] read_mask;  // Bit i reads address i
  } entry_t;

  localparam int NUM_TESTS = 8;

  logic          clk = 1'b0;
  logic          reset, clear_errors, trig, rd_strobe;
  logic          cs_mismatch, unknown_ttc_cmd, ddr3_overflow;
  soft_err_cfg_t soft_err_cfg;
  hard_err_t     hard_err;
  board_stat_t   board_stat;
  status_addr_t  rd_addr;
  status_word_t  rd_data;
  logic          rd_ack;

  entry_t tests [NUM_TESTS];
  integer seed   = 32'h7de5_a620;
  int     errors = 0;
  int     checks = 0;
  int     ticks  = 0;
  int     limit  = 1000000;  // Replaced once the table is known
  int     cycle  = 0;        // Tracks the DUT timestamp counter

  // Reference model
  logic [31:0] m_cnt [3];
  logic [2:0]  m_flag;       // Data corruption, unknown TTC, DDR3 overflow
  logic [23:0] m_trig_num;
  logic [43:0] m_ts;
  logic        m_have_prev;
  logic        m_rate_err;

  rider_status_top rider_status_top_inst (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    ticks <= ticks + 1;
    cycle <= reset ? 0 : cycle + 1;  // Zero in the first cycle out of reset
    if (ticks >= limit) begin
      $display("Timeout after %0d cycles, %0d errors in %0d checks", ticks, errors, checks);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Saturating count, flag once the count is above the threshold
  task automatic count_pulse(input int k, input logic [31:0] thres);
    if (m_cnt[k] != '1) m_cnt[k] = m_cnt[k] + 1;
    if (m_cnt[k] > thres) m_flag[k] = 1'b1;
  endtask

  task automatic note_trigger();
    int gap;
    gap = cycle - int'(m_ts);
    if (m_have_prev && gap < MIN_TRIG_SPACING) m_rate_err = 1'b1;
    m_trig_num  = m_trig_num + 1;
    m_ts        = 44'(cycle);  // Counter value before the capturing edge
    m_have_prev = 1'b1;
  endtask

  function automatic status_word_t expected_word(input int addr);
    status_word_t w;
    w = '0;
    case (addr)
      0: w = {1'b1, 7'd0, MAJOR_REV, MINOR_REV, PATCH_REV};
      1: w[13:0] = {m_flag[2], hard_err.chan_error_rc, hard_err.error_trig_type_from_cm,
                    hard_err.error_trig_type_from_tt, hard_err.error_trig_num_from_cm,
                    hard_err.error_trig_num_from_tt, m_flag[0], m_rate_err, m_flag[1],
                    hard_err.error_pll_unlock};
      2: w[1:0] = {board_stat.daq_clk_sel, board_stat.daq_clk_en};
      3: w[3:0] = {board_stat.adcclk_clkin1_stat, board_stat.adcclk_clkin0_stat,
                   board_stat.adcclk_stat_ld, board_stat.adcclk_stat};
      4: w[1:0] = {board_stat.daq_almost_full, board_stat.daq_ready};
      5: w[10:0] = {board_stat.tts_state, board_stat.ttc_chan_b_info, board_stat.ttc_ready};
      6: w[30:0] = board_stat.cm_state;
      7: w[14:0] = {board_stat.tp_state, board_stat.cac_state, board_stat.ttr_state};
      8: w[12:0] = {board_stat.endianness_sel, board_stat.acq_readout_pause,
                    board_stat.fill_type, board_stat.chan_en};
      9: w[13:0] = {board_stat.trig_settings, board_stat.acq_fifo_full,
                    board_stat.trig_fifo_full, board_stat.trig_delay};
      10: w[23:0] = m_trig_num;
      11: w = m_ts[31:0];
      12: w[11:0] = m_ts[43:32];
      13: w = soft_err_cfg.thres_data_corrupt;
      14: w = m_cnt[0];
      15: w = soft_err_cfg.thres_unknown_ttc;
      16: w = m_cnt[1];
      17: w = soft_err_cfg.thres_ddr3_overflow;
      18: w = m_cnt[2];
      default: w = BAD_ADDR_WORD;  // Past the last status word
    endcase
    return w;
  endfunction

  function automatic int pulse_cycles(input entry_t e);
    int n;
    n = e.n_trig * e.trig_gap;
    if (e.n_cs > n) n = e.n_cs;
    if (e.n_ttc > n) n = e.n_ttc;
    if (e.n_ddr > n) n = e.n_ddr;
    return n;
  endfunction

  function automatic int entry_cycles(input entry_t e);
    return 6 + int'(e.clear) + pulse_cycles(e) + $countones(e.read_mask);
  endfunction

  task automatic check_read(input int addr);
    compare("rd_ack", rd_ack, 1);
    compare($sformatf("rd_data[%0d]", addr), rd_data, expected_word(addr));
  endtask

  task automatic run_entry(input entry_t e);
    logic [127:0] rnd;
    logic [31:0]  hard_rnd;
    int           len;
    int           last_addr;
    bit           pending;
    @(negedge clk);
    rnd = {$random(seed), $random(seed), $random(seed), $random(seed)};
    board_stat   = rnd[$bits(board_stat_t)-1:0];
    hard_rnd     = $random(seed);
    hard_err     = hard_rnd[9:0];
    soft_err_cfg = {e.th_cs, e.th_ttc, e.th_ddr};
    if (e.clear) begin
      @(negedge clk);
      clear_errors = 1'b1;
      m_cnt      = '{default: '0};
      m_flag     = '0;
      m_rate_err = 1'b0;
    end
    len = pulse_cycles(e);
    for (int i = 0; i < len; i++) begin
      @(negedge clk);
      clear_errors    = 1'b0;
      cs_mismatch     = (i < e.n_cs);
      unknown_ttc_cmd = (i < e.n_ttc);
      ddr3_overflow   = (i < e.n_ddr);
      trig            = (i % e.trig_gap == 0) && (i / e.trig_gap < e.n_trig);
      if (cs_mismatch) count_pulse(0, e.th_cs);
      if (unknown_ttc_cmd) count_pulse(1, e.th_ttc);
      if (ddr3_overflow) count_pulse(2, e.th_ddr);
      if (trig) note_trigger();
    end
    @(negedge clk);
    {clear_errors, cs_mismatch, unknown_ttc_cmd, ddr3_overflow, trig} = '0;
    repeat (2) @(negedge clk);  // Front stage plus status register
    pending   = 1'b0;
    last_addr = 0;
    for (int a = 0; a < 32; a++) begin
      if (e.read_mask[a]) begin
        @(negedge clk);
        if (pending) check_read(last_addr);  // Ack of the previous strobe
        rd_strobe = 1'b1;
        rd_addr   = status_addr_t'(a);
        last_addr = a;
        pending   = 1'b1;
      end
    end
    @(negedge clk);
    if (pending) check_read(last_addr);
    rd_strobe = 1'b0;
    @(negedge clk);
    compare("rd_ack", rd_ack, 0);  // No strobe, no ack
  endtask

  initial begin
    int total;
    {reset, clear_errors, cs_mismatch, unknown_ttc_cmd, ddr3_overflow} = 5'b10000;
    {trig, rd_strobe} = 2'b00;
    rd_addr      = '0;
    soft_err_cfg = '0;
    hard_err     = '0;
    board_stat   = '0;
    m_cnt        = '{default: '0};
    {m_flag, m_trig_num, m_ts, m_have_prev, m_rate_err} = '0;
    // clear, n_cs, n_ttc, n_ddr, n_trig, trig_gap, th_cs, th_ttc, th_ddr, read_mask
    tests[0] = '{1'b0, 0, 0, 0, 0, 1, 32'd2, 32'd3, 32'd4, 32'hFFFF_FFFF};
    tests[1] = '{1'b0, 2, 3, 5, 0, 1, 32'd2, 32'd3, 32'd4, 32'h0007_E002};  // Counts at threshold
    tests[2] = '{1'b0, 1, 1, 0, 0, 1, 32'd2, 32'd3, 32'd4, 32'h0005_4002};  // One past
    tests[3] = '{1'b1, 1, 6, 0, 0, 1, 32'd5, 32'd5, 32'd5, 32'h0007_E002};
    tests[4] = '{1'b0, 0, 0, 0, 3, 10, 32'd5, 32'd5, 32'd5, 32'h0000_1C02};  // Wide spacing
    tests[5] = '{1'b0, 0, 0, 0, 2, 3, 32'd5, 32'd5, 32'd5, 32'h0000_1C02};   // Too close
    tests[6] = '{1'b1, 0, 0, 0, 2, 8, 32'd5, 32'd5, 32'd5, 32'h0000_0C02};   // Spacing at limit
    tests[7] = '{1'b0, 4, 2, 3, 4, 9, 32'd1, 32'd7, 32'd0, 32'hFFFF_FFFF};
    total = 0;
    foreach (tests[i]) total += entry_cycles(tests[i]);
    limit = 2 * total + 200;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    compare("rd_ack", rd_ack, 0);
    foreach (tests[i]) run_entry(tests[i]);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== rider_status.f ====
common/rider_status_pkg.sv
hw/soft_error_counter.sv
hw/trigger_capture.sv
status/status_reg_block.sv
status/status_read_port.sv
hw/rider_status_top.sv
verification/rider_status_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rider_status testbench with Verilator
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rider_status_tb -f rider_status.f -o rider_status_sim \
  && ./obj_dir/rider_status_sim > "$LOG" 2>&1 \
  || echo "Simulation failed" >> "$LOG"

cat "$LOG"
grep -q "Simulation failed" "$LOG" && exit 1 || exit 0
